// File: common/io_bridge_defines.svh
`ifndef IO_BRIDGE_DEFINES_SVH
`define IO_BRIDGE_DEFINES_SVH

// Physical address width of a command
`define IO_ADDR_WIDTH 40

// Data width carried by a command
`define IO_DATA_WIDTH 64

// Width of one packed word on the off-chip link
`define IO_LINK_WORD_WIDTH 32

// Requester id width
`define IO_LCE_ID_WIDTH 4

// Default number of entries in the command FIFO
`define IO_CMD_FIFO_DEPTH 4

`endif

// File: common/io_bridge_pkg.sv
`include "io_bridge_defines.svh"

package io_bridge_pkg;

	// Memory message types seen on the command interface
	typedef enum logic [2:0] {
		e_io_uc_rd = 3'b000,
		e_io_uc_wr = 3'b001,
		e_io_rd    = 3'b010,
		e_io_wr    = 3'b011,
		e_io_pre   = 3'b100
	} io_msg_type_e;

	typedef logic [`IO_ADDR_WIDTH-1:0] io_addr_t;

	typedef logic [`IO_DATA_WIDTH-1:0] io_data_t;

	// Encoded access size
	typedef logic [2:0] io_size_t;

	typedef logic [`IO_LCE_ID_WIDTH-1:0] io_lce_id_t;

	// One word as it is sent over the link
	typedef logic [`IO_LINK_WORD_WIDTH-1:0] io_link_word_t;

	typedef logic [7:0] io_link_byte_t;

	// Command header, 50 bits
	typedef struct packed {
		io_msg_type_e msg_type;
		io_size_t     size;
		io_lce_id_t   lce_id;
		io_addr_t     addr;
	} io_cmd_header_s;

	// Full command, 114 bits
	typedef struct packed {
		io_cmd_header_s header;
		io_data_t       data;
	} io_cmd_s;

	// Response mirrors the command layout
	typedef struct packed {
		io_cmd_header_s header;
		io_data_t       data;
	} io_resp_s;

endpackage

// File: hw/io_cmd_fifo.sv
module io_cmd_fifo
	import io_bridge_pkg::*;
	#(parameter depth_p = 2)
	( input                 clk_i
	, input                 reset_i

	, input  io_cmd_s       cmd_i
	, input                 v_i
	, output logic          ready_o

	, output io_cmd_s       cmd_o
	, output logic          v_o
	, input                 yumi_i
	);

	localparam ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
	localparam count_width_lp = $clog2(depth_p + 1);

	io_cmd_s mem_r [depth_p];

	logic [ptr_width_lp-1:0] wr_ptr_r;
	logic [ptr_width_lp-1:0] rd_ptr_r;
	logic [count_width_lp-1:0] count_r;

	logic wr_en;
	logic rd_en;

	assign ready_o = (count_r != count_width_lp'(depth_p));
	assign v_o     = (count_r != '0);
	assign cmd_o   = mem_r[rd_ptr_r];

	assign wr_en = v_i & ready_o;
	assign rd_en = yumi_i;

	// Storage array
	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			mem_r[wr_ptr_r] <= cmd_i;
		end
	end

	// Pointers wrap at depth_p
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			wr_ptr_r <= '0;
			rd_ptr_r <= '0;
		end else begin
			if (wr_en) begin
				if (wr_ptr_r == ptr_width_lp'(depth_p - 1))
					wr_ptr_r <= '0;
				else
					wr_ptr_r <= wr_ptr_r + 1'b1;
			end
			if (rd_en) begin
				if (rd_ptr_r == ptr_width_lp'(depth_p - 1))
					rd_ptr_r <= '0;
				else
					rd_ptr_r <= rd_ptr_r + 1'b1;
			end
		end
	end

	// Occupancy, unchanged on simultaneous push and pop
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			count_r <= '0;
		end else if (wr_en & ~rd_en) begin
			count_r <= count_r + 1'b1;
		end else if (rd_en & ~wr_en) begin
			count_r <= count_r - 1'b1;
		end
	end

endmodule

// File: io_decoder/io_decoder.sv
module io_decoder
	import io_bridge_pkg::*;
	( input                   clk_i
	, input                   reset_i

	, input  io_cmd_s         io_cmd_i
	, input                   io_cmd_v_i
	, output logic            io_cmd_ready_and_o

	, output io_resp_s        io_resp_o
	, output logic            io_resp_v_o
	, input                   io_resp_yumi_i

	, output io_link_word_t   data_o
	, output logic            v_o
	, input                   ready_i
	);

	io_cmd_header_s header_r;
	logic           resp_v_r;

	logic is_uc_wr;
	logic is_uc_rd;
	logic word_accept;

	// Classify the command at the head
	assign is_uc_wr = (io_cmd_i.header.msg_type == e_io_uc_wr);
	assign is_uc_rd = (io_cmd_i.header.msg_type == e_io_uc_rd);

	// Hold off while a response is still waiting
	assign io_cmd_ready_and_o = ready_i & ~resp_v_r;

	assign v_o = io_cmd_v_i & (is_uc_wr | is_uc_rd) & io_cmd_ready_and_o;

	assign word_accept = v_o & ready_i;

	// Write flag, low address bits, low data bits
	assign data_o = {is_uc_wr, io_cmd_i.header.addr[15:0], io_cmd_i.data[14:0]};

	// Header is captured only with a sent word
	always_ff @(posedge clk_i) begin
		if (word_accept) begin
			header_r <= io_cmd_i.header;
		end
	end

	// Response valid, set by a sent word and cleared by yumi
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			resp_v_r <= 1'b0;
		end else if (word_accept) begin
			resp_v_r <= 1'b1;
		end else if (io_resp_yumi_i) begin
			resp_v_r <= 1'b0;
		end
	end

	assign io_resp_v_o = resp_v_r;

	// No read data comes back from the link
	assign io_resp_o = '{header: header_r, data: '0};

endmodule

// File: io_decoder/io_link_tx.sv
module io_link_tx
	import io_bridge_pkg::*;
	( input                   clk_i
	, input                   reset_i

	, input  io_link_word_t   word_i
	, input                   v_i
	, output logic            ready_o

	, output io_link_byte_t   link_data_o
	, output logic            link_v_o
	, input                   link_ready_i
	);

	localparam byte_width_lp = $bits(io_link_byte_t);
	localparam word_width_lp = $bits(io_link_word_t);
	localparam num_bytes_lp  = word_width_lp / byte_width_lp;
	localparam cnt_width_lp  = $clog2(num_bytes_lp);

	typedef enum logic {
		e_tx_idle,
		e_tx_send
	} tx_state_e;

	tx_state_e state_r;
	tx_state_e state_n;

	io_link_word_t             shift_r;
	logic [cnt_width_lp-1:0]   cnt_r;

	logic load;
	logic byte_sent;
	logic last_byte;

	assign ready_o  = (state_r == e_tx_idle);
	assign link_v_o = (state_r == e_tx_send);

	// MSB first
	assign link_data_o = shift_r[word_width_lp-1 -: byte_width_lp];

	assign load      = ready_o & v_i;
	assign byte_sent = link_v_o & link_ready_i;
	assign last_byte = (cnt_r == cnt_width_lp'(num_bytes_lp - 1));

	always_comb begin
		state_n = state_r;
		case (state_r)
			e_tx_idle: begin
				if (v_i)
					state_n = e_tx_send;
			end
			e_tx_send: begin
				if (byte_sent & last_byte)
					state_n = e_tx_idle;
			end
			default: state_n = e_tx_idle;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			state_r <= e_tx_idle;
		end else begin
			state_r <= state_n;
		end
	end

	// Byte counter restarts with every new word
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			cnt_r <= '0;
		end else if (load) begin
			cnt_r <= '0;
		end else if (byte_sent) begin
			cnt_r <= cnt_r + 1'b1;
		end
	end

	always_ff @(posedge clk_i) begin
		if (load) begin
			shift_r <= word_i;
		end else if (byte_sent) begin
			shift_r <= shift_r << byte_width_lp;
		end
	end

endmodule

// File: hw/io_bridge_top.sv
`include "io_bridge_defines.svh"

module io_bridge_top
	import io_bridge_pkg::*;
	( input                   clk_i
	, input                   reset_i

	, input  io_cmd_s         io_cmd_i
	, input                   io_cmd_v_i
	, output logic            io_cmd_ready_and_o

	, output io_resp_s        io_resp_o
	, output logic            io_resp_v_o
	, input                   io_resp_yumi_i

	, output io_link_byte_t   link_data_o
	, output logic            link_v_o
	, input                   link_ready_i
	);

	io_cmd_s       fifo_cmd;
	logic          fifo_v;
	logic          dec_ready;

	io_link_word_t link_word;
	logic          word_v;
	logic          tx_ready;

	io_cmd_fifo
		#(.depth_p(`IO_CMD_FIFO_DEPTH))
		cmd_fifo
		(.clk_i(clk_i)
		,.reset_i(reset_i)
		,.cmd_i(io_cmd_i)
		,.v_i(io_cmd_v_i)
		,.ready_o(io_cmd_ready_and_o)
		,.cmd_o(fifo_cmd)
		,.v_o(fifo_v)
		,.yumi_i(fifo_v & dec_ready)
		);

	io_decoder
		decoder
		(.clk_i(clk_i)
		,.reset_i(reset_i)
		,.io_cmd_i(fifo_cmd)
		,.io_cmd_v_i(fifo_v)
		,.io_cmd_ready_and_o(dec_ready)
		,.io_resp_o(io_resp_o)
		,.io_resp_v_o(io_resp_v_o)
		,.io_resp_yumi_i(io_resp_yumi_i)
		,.data_o(link_word)
		,.v_o(word_v)
		,.ready_i(tx_ready)
		);

	io_link_tx
		link_tx
		(.clk_i(clk_i)
		,.reset_i(reset_i)
		,.word_i(link_word)
		,.v_i(word_v)
		,.ready_o(tx_ready)
		,.link_data_o(link_data_o)
		,.link_v_o(link_v_o)
		,.link_ready_i(link_ready_i)
		);

endmodule

// File: verif/io_bridge_assertions.sv
module io_bridge_assertions
	import io_bridge_pkg::*;
	( input                 clk_i
	, input                 reset_i
	, input  io_link_byte_t link_data_i
	, input                 link_v_i
	, input                 link_ready_i
	, input                 io_resp_v_i
	, input                 io_resp_yumi_i
	);

	// Failures seen so far
	int error_count = 0;

	// Byte held until the link takes it
	link_hold: assert property (@(posedge clk_i) disable iff (reset_i)
		link_v_i && !link_ready_i |=> link_v_i && $stable(link_data_i))
		else begin
			$error("link byte changed or dropped before link ready");
			error_count = error_count + 1;
		end

	yumi_only_when_valid: assert property (@(posedge clk_i) disable iff (reset_i)
		io_resp_yumi_i |-> io_resp_v_i)
		else begin
			$error("response yumi seen without response valid");
			error_count = error_count + 1;
		end

	// First cycle out of reset
	resp_low_after_reset: assert property (@(posedge clk_i)
		$fell(reset_i) |-> !io_resp_v_i)
		else begin
			$error("response valid high right after reset");
			error_count = error_count + 1;
		end

endmodule

bind io_bridge_top io_bridge_assertions assertions_inst
	(.clk_i(clk_i)
	,.reset_i(reset_i)
	,.link_data_i(link_data_o)
	,.link_v_i(link_v_o)
	,.link_ready_i(link_ready_i)
	,.io_resp_v_i(io_resp_v_o)
	,.io_resp_yumi_i(io_resp_yumi_i)
	);

// File: verif/io_bridge_tb.sv
module io_bridge_tb
	import io_bridge_pkg::*;
	();

	localparam int clk_period_lp = 40;
	localparam int drive_delay_lp = 2;
	// The directed tests need a few hundred cycles, so this leaves ample margin
	localparam int timeout_cycles_lp = 4000;
	localparam logic [31:0] seed_lp = 32'h01b6_3242;

	logic          clk;
	logic          reset;
	io_cmd_s       io_cmd;
	logic          io_cmd_v;
	logic          io_cmd_ready_and;
	io_resp_s      io_resp;
	logic          io_resp_v;
	logic          io_resp_yumi;
	io_link_byte_t link_data;
	logic          link_v;
	logic          link_ready;

	io_link_byte_t link_bytes [$];
	io_link_word_t exp_words [$];
	io_resp_s      exp_resps [$];
	io_cmd_s       batch [$];

	logic [31:0] rng_state;
	logic [31:0] link_rng_state;
	logic        link_random;
	logic        saw_full;
	int          cycle_count = 0;

	io_bridge_top io_bridge_top_inst
		(.clk_i(clk)
		,.reset_i(reset)
		,.io_cmd_i(io_cmd)
		,.io_cmd_v_i(io_cmd_v)
		,.io_cmd_ready_and_o(io_cmd_ready_and)
		,.io_resp_o(io_resp)
		,.io_resp_v_o(io_resp_v)
		,.io_resp_yumi_i(io_resp_yumi)
		,.link_data_o(link_data)
		,.link_v_o(link_v)
		,.link_ready_i(link_ready)
		);

	initial begin
		clk = 1'b0;
		forever #(clk_period_lp / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles_lp) begin
			$display("Timeout: the tests did not finish within %0d cycles", timeout_cycles_lp);
			$display("Verification failed");
			$fatal(1, "timeout");
		end
	end

	// Bound assertions count their failures
	always @(posedge clk) begin
		if (io_bridge_top_inst.assertions_inst.error_count != 0) begin
			$display("A bound assertion failed, see the error above");
			$display("Verification failed");
			$fatal(1, "assertion failed");
		end
	end

	// Link monitor
	always @(posedge clk) begin
		if (!reset && link_v && link_ready)
			link_bytes.push_back(link_data);
	end

	// Link ready, random only while back-pressure is on
	always @(posedge clk) begin
		#(drive_delay_lp);
		if (link_random) begin
			link_rng_state = xorshift(link_rng_state);
			link_ready = link_rng_state[0];
		end else begin
			link_ready = 1'b1;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic is_uncached(input io_cmd_s cmd);
		return (cmd.header.msg_type == e_io_uc_rd) || (cmd.header.msg_type == e_io_uc_wr);
	endfunction

	// Write flag, then addr[15:0], then data[14:0]
	function automatic io_link_word_t expected_word(input io_cmd_s cmd);
		logic wr_flag;
		wr_flag = (cmd.header.msg_type == e_io_uc_wr);
		return {wr_flag, cmd.header.addr[15:0], cmd.data[14:0]};
	endfunction

	function automatic io_cmd_s make_cmd(input io_msg_type_e t, input io_addr_t a, input io_data_t d);
		io_cmd_s c;
		c.header.msg_type = t;
		c.header.size = 3'b011;
		c.header.lce_id = a[3:0] ^ 4'h5;
		c.header.addr = a;
		c.data = d;
		return c;
	endfunction

	task automatic random_cmd(output io_cmd_s c);
		logic [31:0] r0;
		logic [31:0] r1;
		rng_state = xorshift(rng_state);
		r0 = rng_state;
		rng_state = xorshift(rng_state);
		r1 = rng_state;
		c = make_cmd(r0[0] ? e_io_uc_wr : e_io_uc_rd, {r0[15:8], r1}, {r1, r0});
		c.header.size = r0[18:16];
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Verification failed");
		$fatal(1, "check failed");
	endtask

	task automatic check_link_word(input io_link_word_t got, input io_link_word_t exp);
		if (got !== exp) begin
			$display("error at %0t: link word %h, expected %h", $time, got, exp);
			$display("Verification failed");
			$fatal(1, "link word mismatch");
		end
	endtask

	task automatic check_resp(input io_resp_s got, input io_resp_s exp);
		if (got !== exp) begin
			$display("error at %0t: response %h, expected %h", $time, got, exp);
			$display("Verification failed");
			$fatal(1, "response mismatch");
		end
	endtask

	task automatic send_cmd(input io_cmd_s cmd);
		logic     accepted;
		io_resp_s r;
		if (is_uncached(cmd)) begin
			exp_words.push_back(expected_word(cmd));
			r.header = cmd.header;
			r.data = '0;
			exp_resps.push_back(r);
		end
		io_cmd = cmd;
		io_cmd_v = 1'b1;
		accepted = 1'b0;
		while (!accepted) begin
			@(posedge clk);
			accepted = io_cmd_ready_and;
			if (!accepted)
				saw_full = 1'b1;
			#(drive_delay_lp);
		end
		io_cmd_v = 1'b0;
	endtask

	task automatic take_resp();
		while (!io_resp_v) begin
			@(posedge clk);
			#(drive_delay_lp);
		end
		if (exp_resps.size() == 0)
			report_failure("A response came back with no command outstanding");
		check_resp(io_resp, exp_resps.pop_front());
		io_resp_yumi = 1'b1;
		@(posedge clk);
		#(drive_delay_lp);
		io_resp_yumi = 1'b0;
	endtask

	task automatic check_next_word();
		io_link_word_t got;
		while (link_bytes.size() < 4) begin
			@(posedge clk);
			#(drive_delay_lp);
		end
		for (int i = 0; i < 4; i++)
			got = {got[23:0], link_bytes.pop_front()};
		check_link_word(got, exp_words.pop_front());
	endtask

	// Link stays silent, response valid stays at resp_v
	task automatic hold_quiet(input int cycles, input logic resp_v);
		repeat (cycles) begin
			@(posedge clk);
			#(drive_delay_lp);
			if (link_v || link_bytes.size() != 0)
				report_failure("Link bytes appeared where no link word was expected");
			if (io_resp_v !== resp_v)
				report_failure("Response valid was not at the expected level");
		end
	endtask

	task automatic run_batch();
		int n_uc;
		n_uc = 0;
		foreach (batch[i])
			if (is_uncached(batch[i]))
				n_uc++;
		fork
			foreach (batch[i])
				send_cmd(batch[i]);
			repeat (n_uc) take_resp();
			repeat (n_uc) check_next_word();
		join
		batch.delete();
	endtask

	task automatic write_passes_through();
		batch.push_back(make_cmd(e_io_uc_wr, 40'h12_3456_abcd, 64'hdead_beef_cafe_1234));
		run_batch();
	endtask

	task automatic read_passes_through();
		batch.push_back(make_cmd(e_io_uc_rd, 40'h00_8765_4321, 64'h0123_4567_89ab_fedc));
		run_batch();
	endtask

	task automatic dropped_types_vanish();
		batch.push_back(make_cmd(e_io_rd, 40'h00_0000_1111, 64'h1));
		batch.push_back(make_cmd(e_io_wr, 40'h00_0000_2222, 64'h2));
		batch.push_back(make_cmd(e_io_pre, 40'h00_0000_3333, 64'h3));
		run_batch();
		hold_quiet(20, 1'b0);
		batch.push_back(make_cmd(e_io_uc_wr, 40'h55_aaaa_5a5a, 64'h0000_0000_0000_7fff));
		run_batch();
	endtask

	task automatic backpressure_holds_order();
		io_cmd_s c;
		saw_full = 1'b0;
		link_random = 1'b1;
		repeat (8) begin
			random_cmd(c);
			batch.push_back(c);
		end
		run_batch();
		link_random = 1'b0;
		if (!saw_full)
			report_failure("Command ready never fell while the link was stalled");
	endtask

	task automatic response_stalls_next();
		send_cmd(make_cmd(e_io_uc_wr, 40'h01_0203_0405, 64'h0607_0809_0a0b_0c0d));
		send_cmd(make_cmd(e_io_uc_rd, 40'hfe_fdfc_fbfa, 64'hf9f8_f7f6_f5f4_f3f2));
		check_next_word();
		hold_quiet(20, 1'b1);
		take_resp();
		check_next_word();
		take_resp();
	endtask

	task automatic random_burst_in_order();
		io_cmd_s c;
		repeat (30) begin
			random_cmd(c);
			batch.push_back(c);
		end
		run_batch();
	endtask

	initial begin
		io_cmd = '0;
		io_cmd_v = 1'b0;
		io_resp_yumi = 1'b0;
		link_ready = 1'b1;
		reset = 1'b1;
		link_random = 1'b0;
		saw_full = 1'b0;
		rng_state = seed_lp;
		link_rng_state = seed_lp;
		repeat (3) @(posedge clk);
		#(drive_delay_lp);
		reset = 1'b0;
		write_passes_through();
		read_passes_through();
		dropped_types_vanish();
		backpressure_holds_order();
		response_stalls_next();
		random_burst_in_order();
		if (io_bridge_top_inst.assertions_inst.error_count != 0) begin
			$display("A bound assertion failed, see the error above");
			$display("Verification failed");
			$fatal(1, "assertion failed");
		end else begin
			$display("Verification passed");
			$finish;
		end
	end

endmodule

// File: io_bridge.f
+incdir+common
common/io_bridge_pkg.sv
hw/io_cmd_fifo.sv
io_decoder/io_decoder.sv
io_decoder/io_link_tx.sv
hw/io_bridge_top.sv
verif/io_bridge_assertions.sv
verif/io_bridge_tb.sv

// File: Bender.yml
package:
  name: io_bridge

sources:
  - include_dirs:
      - common
    files:
      - common/io_bridge_pkg.sv
      - hw/io_cmd_fifo.sv
      - io_decoder/io_decoder.sv
      - io_decoder/io_link_tx.sv
      - hw/io_bridge_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - verif/io_bridge_assertions.sv
      - verif/io_bridge_tb.sv
